//--- hdl/mips_defs.svh
// MIPS core parameters
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data path and bus address width
`define MIPS_XLEN 32

// Register file addressing
`define MIPS_RA_W 5
`define MIPS_NREGS 32

// First instruction fetch address
`define MIPS_RESET_PC 32'h0000_0000

`endif

//--- hdl/mips_pkg.sv
// MIPS core types
`default_nettype none

package mips_pkg;

	// Primary opcode field
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	// R-type function field
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD  = 3'd0,
		ALU_SUB  = 3'd1,
		ALU_AND  = 3'd2,
		ALU_OR   = 3'd3,
		ALU_SLT  = 3'd4,
		ALU_LUI  = 3'd5,
		ALU_PASS = 3'd6
	} alu_op_e;

	typedef enum logic [3:0] {
		S_FETCH,
		S_DECODE,
		S_MEM_ADDR,
		S_MEM_READ,
		S_MEM_WB,
		S_MEM_WRITE,
		S_ALU_EXEC,
		S_ALU_WB,
		S_BRANCH,
		S_JUMP
	} state_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    imm_zero_ext;
		logic    reg_dst_rd;
		logic    mem_to_reg;
		logic    reg_write;
		logic    ir_write;
		logic    mdr_write;
		logic    pc_inc;
		logic    pc_branch;
		logic    pc_jump;
	} ctrl_t;

	// Low half is either rd/shamt/funct or the immediate
	typedef struct packed {
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} rfields_t;

	typedef union packed {
		rfields_t    r;
		logic [15:0] imm;
	} low_t;

	typedef struct packed {
		opcode_e    op;
		logic [4:0] rs;
		logic [4:0] rt;
		low_t       lo;
	} instr_t;

endpackage

`default_nettype wire

//--- hdl/regfile.sv
// Three-ported register file
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module regfile (
	input  logic                  clk,
	input  logic                  we3,
	input  logic [`MIPS_RA_W-1:0] ra1,
	input  logic [`MIPS_RA_W-1:0] ra2,
	input  logic [`MIPS_RA_W-1:0] wa3,
	input  logic [`MIPS_XLEN-1:0] wd3,
	output logic [`MIPS_XLEN-1:0] rd1,
	output logic [`MIPS_XLEN-1:0] rd2
);
	logic [`MIPS_XLEN-1:0] rf [`MIPS_NREGS];

	// Write port on the rising edge
	always_ff @(posedge clk) begin
		if (we3) begin
			rf[wa3] <= wd3;
		end
	end

	// Register 0 is hardwired to zero
	assign rd1 = (ra1 != '0) ? rf[ra1] : '0;
	assign rd2 = (ra2 != '0) ? rf[ra2] : '0;

endmodule

`default_nettype wire

//--- hdl/mips_decode.sv
// Multicycle controller
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
	input  logic             clk,
	input  logic             rst,
	input  mips_pkg::instr_t instr,
	input  logic             wb_ack,
	output mips_pkg::ctrl_t  ctrl,
	output logic             wb_cyc,
	output logic             wb_stb,
	output logic             wb_we,
	output logic             data_phase
);
	mips_pkg::state_e  state_q;
	mips_pkg::state_e  state_d;
	mips_pkg::ctrl_t   ctrl_d;
	mips_pkg::alu_op_e alu_op;
	logic              funct_ok;
	logic              bus_q;
	logic              done;

	// Transfer completes on ack of our own strobe
	assign done = bus_q & wb_ack;

	// ALU operation from opcode and funct
	always_comb begin
		alu_op = mips_pkg::ALU_PASS;
		funct_ok = 1'b1;
		case (instr.op)
			mips_pkg::OP_RTYPE: begin
				case (instr.lo.r.funct)
					mips_pkg::FN_ADD: alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:  alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
					default:          funct_ok = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDI, mips_pkg::OP_LW, mips_pkg::OP_SW: alu_op = mips_pkg::ALU_ADD;
			mips_pkg::OP_ORI: alu_op = mips_pkg::ALU_OR;
			mips_pkg::OP_LUI: alu_op = mips_pkg::ALU_LUI;
			mips_pkg::OP_BEQ: alu_op = mips_pkg::ALU_SUB;
			default: funct_ok = 1'b0;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			mips_pkg::S_FETCH: if (done) state_d = mips_pkg::S_DECODE;
			mips_pkg::S_DECODE: begin
				case (instr.op)
					mips_pkg::OP_RTYPE: begin
						state_d = funct_ok ? mips_pkg::S_ALU_EXEC : mips_pkg::S_FETCH;
					end
					mips_pkg::OP_ADDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
						state_d = mips_pkg::S_ALU_EXEC;
					end
					mips_pkg::OP_LW, mips_pkg::OP_SW: state_d = mips_pkg::S_MEM_ADDR;
					mips_pkg::OP_BEQ: state_d = mips_pkg::S_BRANCH;
					mips_pkg::OP_J:   state_d = mips_pkg::S_JUMP;
					// Unknown opcode is dropped
					default: state_d = mips_pkg::S_FETCH;
				endcase
			end
			mips_pkg::S_MEM_ADDR: begin
				if (instr.op == mips_pkg::OP_LW) begin
					state_d = mips_pkg::S_MEM_READ;
				end else begin
					state_d = mips_pkg::S_MEM_WRITE;
				end
			end
			mips_pkg::S_MEM_READ:  if (done) state_d = mips_pkg::S_MEM_WB;
			mips_pkg::S_MEM_WRITE: if (done) state_d = mips_pkg::S_FETCH;
			mips_pkg::S_ALU_EXEC:  state_d = mips_pkg::S_ALU_WB;
			default:               state_d = mips_pkg::S_FETCH;
		endcase
	end

	// Control for the coming state, registered below
	always_comb begin
		ctrl_d = '0;
		ctrl_d.alu_op = mips_pkg::ALU_PASS;
		case (state_d)
			mips_pkg::S_FETCH: begin
				ctrl_d.ir_write = 1'b1;
				ctrl_d.pc_inc = 1'b1;
			end
			// Address held in the ALU register through the access
			mips_pkg::S_MEM_ADDR, mips_pkg::S_MEM_READ, mips_pkg::S_MEM_WRITE,
			mips_pkg::S_MEM_WB: begin
				ctrl_d.alu_op = mips_pkg::ALU_ADD;
				ctrl_d.alu_src_imm = 1'b1;
				ctrl_d.mdr_write = (state_d == mips_pkg::S_MEM_READ);
				ctrl_d.mem_to_reg = (state_d == mips_pkg::S_MEM_WB);
				ctrl_d.reg_write = (state_d == mips_pkg::S_MEM_WB);
			end
			mips_pkg::S_ALU_EXEC, mips_pkg::S_ALU_WB: begin
				ctrl_d.alu_op = alu_op;
				ctrl_d.alu_src_imm = (instr.op != mips_pkg::OP_RTYPE);
				ctrl_d.imm_zero_ext = (instr.op == mips_pkg::OP_ORI);
				ctrl_d.reg_dst_rd = (instr.op == mips_pkg::OP_RTYPE);
				ctrl_d.reg_write = (state_d == mips_pkg::S_ALU_WB);
			end
			mips_pkg::S_BRANCH: begin
				ctrl_d.alu_op = mips_pkg::ALU_SUB;
				ctrl_d.pc_branch = 1'b1;
			end
			mips_pkg::S_JUMP: ctrl_d.pc_jump = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= mips_pkg::S_FETCH;
			ctrl <= '0;
			bus_q <= 1'b0;
			wb_we <= 1'b0;
			data_phase <= 1'b0;
		end else begin
			state_q <= state_d;
			ctrl <= ctrl_d;
			bus_q <= (state_d == mips_pkg::S_FETCH) || (state_d == mips_pkg::S_MEM_READ) ||
				(state_d == mips_pkg::S_MEM_WRITE);
			wb_we <= (state_d == mips_pkg::S_MEM_WRITE);
			data_phase <= (state_d == mips_pkg::S_MEM_READ) ||
				(state_d == mips_pkg::S_MEM_WRITE);
		end
	end

	assign wb_cyc = bus_q;
	assign wb_stb = bus_q;

endmodule

`default_nettype wire

//--- hdl/mips_execute.sv
// ALU and program counter
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_execute (
	input  logic                  clk,
	input  logic                  rst,
	input  mips_pkg::ctrl_t       ctrl,
	input  mips_pkg::instr_t      instr,
	input  logic [`MIPS_XLEN-1:0] rd1,
	input  logic [`MIPS_XLEN-1:0] rd2,
	input  logic                  wb_ack,
	output logic [`MIPS_XLEN-1:0] pc,
	output logic [`MIPS_XLEN-1:0] alu_out
);
	logic [15:0]           imm;
	logic [`MIPS_XLEN-1:0] imm_sext;
	logic [`MIPS_XLEN-1:0] imm_ext;
	logic [`MIPS_XLEN-1:0] b;
	logic [`MIPS_XLEN-1:0] alu_res;
	logic [`MIPS_XLEN-1:0] br_target;
	logic [`MIPS_XLEN-1:0] j_target;
	logic                  equal;

	assign imm = instr.lo.imm;
	assign imm_sext = {{(`MIPS_XLEN-16){imm[15]}}, imm};
	// ori takes the immediate unsigned
	assign imm_ext = ctrl.imm_zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm} : imm_sext;
	assign b = ctrl.alu_src_imm ? imm_ext : rd2;

	always_comb begin
		case (ctrl.alu_op)
			mips_pkg::ALU_ADD: alu_res = rd1 + b;
			mips_pkg::ALU_SUB: alu_res = rd1 - b;
			mips_pkg::ALU_AND: alu_res = rd1 & b;
			mips_pkg::ALU_OR:  alu_res = rd1 | b;
			mips_pkg::ALU_SLT: alu_res = {{(`MIPS_XLEN-1){1'b0}}, $signed(rd1) < $signed(b)};
			mips_pkg::ALU_LUI: alu_res = {b[15:0], {(`MIPS_XLEN-16){1'b0}}};
			default:           alu_res = b;
		endcase
	end

	// PC already points past the branch when these are used
	assign equal = (rd1 == rd2);
	assign br_target = pc + {imm_sext[`MIPS_XLEN-3:0], 2'b00};
	assign j_target = {pc[`MIPS_XLEN-1:28], instr.rs, instr.rt, imm, 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `MIPS_RESET_PC;
		end else if (ctrl.pc_inc && wb_ack) begin
			pc <= pc + `MIPS_XLEN'd4;
		end else if (ctrl.pc_branch && equal) begin
			pc <= br_target;
		end else if (ctrl.pc_jump) begin
			pc <= j_target;
		end
	end

	// ALU result register, loaded every cycle
	always_ff @(posedge clk) begin
		alu_out <= alu_res;
	end

endmodule

`default_nettype wire

//--- hdl/mips_result.sv
// Instruction and data registers, write-back
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_result (
	input  logic                  clk,
	input  logic                  rst,
	input  mips_pkg::ctrl_t       ctrl,
	input  logic [`MIPS_XLEN-1:0] wb_rdata,
	input  logic                  wb_ack,
	input  logic [`MIPS_XLEN-1:0] alu_out,
	output mips_pkg::instr_t      instr,
	output logic                  we3,
	output logic [`MIPS_RA_W-1:0] wa3,
	output logic [`MIPS_XLEN-1:0] wd3
);
	logic [`MIPS_XLEN-1:0] mdr;

	// Instruction register, captured on fetch ack
	always_ff @(posedge clk) begin
		if (rst) begin
			instr <= '0;
		end else if (ctrl.ir_write && wb_ack) begin
			instr <= mips_pkg::instr_t'(wb_rdata);
		end
	end

	// Load data
	always_ff @(posedge clk) begin
		if (ctrl.mdr_write && wb_ack) begin
			mdr <= wb_rdata;
		end
	end

	assign we3 = ctrl.reg_write;
	assign wa3 = ctrl.reg_dst_rd ? instr.lo.r.rd : instr.rt;
	assign wd3 = ctrl.mem_to_reg ? mdr : alu_out;

endmodule

`default_nettype wire

//--- hdl/mips_core.sv
// Multicycle MIPS core, Wishbone master
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_core (
	input  logic                  clk,
	input  logic                  rst,
	output logic                  wb_cyc,
	output logic                  wb_stb,
	output logic                  wb_we,
	output logic [`MIPS_XLEN-1:0] wb_adr,
	output logic [`MIPS_XLEN-1:0] wb_wdata,
	input  logic [`MIPS_XLEN-1:0] wb_rdata,
	input  logic                  wb_ack
);
	mips_pkg::ctrl_t       ctrl;
	mips_pkg::instr_t      instr;
	logic                  data_phase;
	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] alu_out;
	logic [`MIPS_XLEN-1:0] rd1;
	logic [`MIPS_XLEN-1:0] wd3;
	logic [`MIPS_RA_W-1:0] wa3;
	logic                  we3;

	// Fetch from the PC, data accesses from the ALU register
	assign wb_adr = data_phase ? alu_out : pc;

	mips_decode decode_i (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.wb_ack     (wb_ack),
		.ctrl       (ctrl),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.data_phase (data_phase)
	);

	mips_execute execute_i (
		.clk     (clk),
		.rst     (rst),
		.ctrl    (ctrl),
		.instr   (instr),
		.rd1     (rd1),
		.rd2     (wb_wdata),
		.wb_ack  (wb_ack),
		.pc      (pc),
		.alu_out (alu_out)
	);

	mips_result result_i (
		.clk      (clk),
		.rst      (rst),
		.ctrl     (ctrl),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack),
		.alu_out  (alu_out),
		.instr    (instr),
		.we3      (we3),
		.wa3      (wa3),
		.wd3      (wd3)
	);

	// Store data comes straight from read port 2
	regfile regfile_i (
		.clk (clk),
		.we3 (we3),
		.ra1 (instr.rs),
		.ra2 (instr.rt),
		.wa3 (wa3),
		.wd3 (wd3),
		.rd1 (rd1),
		.rd2 (wb_wdata)
	);

endmodule

`default_nettype wire

//--- tb/mips_core_asserts.sv
// Wishbone handshake checks
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_core_asserts (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  logic [`MIPS_XLEN-1:0] wb_adr,
	input  logic [`MIPS_XLEN-1:0] wb_wdata,
	input  logic                  wb_ack
);
	int unsigned failures;

	initial failures = 0;

	stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
		else begin
			$error("wb_stb high outside a bus cycle");
			failures++;
		end

	// Request held until the slave acks
	hold_until_ack: assert property (@(posedge clk) disable iff (rst)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_wdata))
		else begin
			$error("bus request changed before wb_ack");
			failures++;
		end

	quiet_in_reset: assert property (@(posedge clk) rst |=> !wb_stb)
		else begin
			$error("wb_stb raised during reset");
			failures++;
		end

	word_aligned: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_adr[1:0] == 2'b00)
		else begin
			$error("wb_adr not word aligned");
			failures++;
		end

endmodule

bind mips_core mips_core_asserts asserts_i (
	.clk      (clk),
	.rst      (rst),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_we    (wb_we),
	.wb_adr   (wb_adr),
	.wb_wdata (wb_wdata),
	.wb_ack   (wb_ack)
);

`default_nettype wire

//--- tb/mips_core_tb.sv
// Testbench for the multicycle MIPS core
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mips_core_tb;

	typedef struct packed {
		logic [`MIPS_XLEN-1:0] adr;
		logic [`MIPS_XLEN-1:0] data;
	} store_t;

	// Standard MIPS encodings
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	localparam int max_wait = 2000;
	localparam logic [31:0] halt_adr = 32'h0000_007c;

	logic                  clk;
	logic                  rst;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [`MIPS_XLEN-1:0] wb_adr;
	logic [`MIPS_XLEN-1:0] wb_wdata;
	logic [`MIPS_XLEN-1:0] wb_rdata = '0;
	logic                  wb_ack = 1'b0;

	logic [31:0] mem [256];
	logic [1:0]  wait_left;
	integer      seed = 32'hdd5994f0;

	store_t      stores[$];
	store_t      expected[$];
	logic [31:0] fetches[$];
	logic [31:0] expected_fetch[$];
	int          next_word;
	int          passed;
	int          failed;
	logic        timed_out;

	mips_core mips_core_i (
		.clk      (clk),
		.rst      (rst),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// Word memory, acks after 0 to 3 random wait cycles
	always @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			wait_left <= 2'($random(seed));
		end else if (wb_ack) begin
			wb_ack <= 1'b0;
			wait_left <= 2'($random(seed));
		end else if (wb_cyc && wb_stb) begin
			if (wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				wb_ack <= 1'b1;
				if (wb_we) begin
					mem[wb_adr[9:2]] <= wb_wdata;
					stores.push_back({wb_adr, wb_wdata});
				end else begin
					wb_rdata <= mem[wb_adr[9:2]];
					// Program area only, loads go above it
					if (wb_adr < 32'h200) begin
						fetches.push_back(wb_adr);
					end
				end
			end
		end
	end

	function automatic logic [31:0] rtype_word(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_word(input logic [31:0] target);
		return {op_j, target[27:2]};
	endfunction

	task automatic place_word(input logic [31:0] word);
		mem[next_word] = word;
		next_word++;
	endtask

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'h5a5a_0000 | 32'(i * 4);
		end
		next_word = 0;
		place_word(itype_word(op_addi, 5'd0, 5'd1, 16'd7));
		place_word(itype_word(op_addi, 5'd0, 5'd2, 16'hfffd));
		place_word(rtype_word(5'd1, 5'd2, 5'd3, fn_add));
		place_word(itype_word(op_sw, 5'd0, 5'd3, 16'h0300));
		place_word(rtype_word(5'd1, 5'd2, 5'd4, fn_sub));
		place_word(itype_word(op_sw, 5'd0, 5'd4, 16'h0304));
		place_word(rtype_word(5'd1, 5'd2, 5'd5, fn_and));
		place_word(itype_word(op_sw, 5'd0, 5'd5, 16'h0308));
		place_word(rtype_word(5'd1, 5'd2, 5'd6, fn_or));
		place_word(itype_word(op_sw, 5'd0, 5'd6, 16'h030c));
		place_word(rtype_word(5'd2, 5'd1, 5'd7, fn_slt));
		place_word(itype_word(op_sw, 5'd0, 5'd7, 16'h0310));
		place_word(rtype_word(5'd1, 5'd2, 5'd8, fn_slt));
		place_word(itype_word(op_sw, 5'd0, 5'd8, 16'h0314));
		place_word(itype_word(op_sw, 5'd0, 5'd2, 16'h0318));
		place_word(itype_word(op_ori, 5'd0, 5'd9, 16'h8001));
		place_word(itype_word(op_sw, 5'd0, 5'd9, 16'h031c));
		place_word(itype_word(op_lui, 5'd0, 5'd10, 16'h1234));
		place_word(itype_word(op_ori, 5'd10, 5'd10, 16'habcd));
		place_word(itype_word(op_sw, 5'd0, 5'd10, 16'h0320));
		place_word(itype_word(op_lw, 5'd0, 5'd11, 16'h0200));
		place_word(itype_word(op_sw, 5'd0, 5'd11, 16'h0324));
		place_word(itype_word(op_addi, 5'd0, 5'd0, 16'd5));
		place_word(itype_word(op_sw, 5'd0, 5'd0, 16'h0328));
		// 0x60: taken branch over the store at 0x64
		place_word(itype_word(op_beq, 5'd1, 5'd1, 16'd1));
		place_word(itype_word(op_sw, 5'd0, 5'd1, 16'h0340));
		place_word(itype_word(op_beq, 5'd1, 5'd2, 16'd1));
		place_word(itype_word(op_sw, 5'd0, 5'd1, 16'h032c));
		// 0x70: jump over the store at 0x74
		place_word(jump_word(32'h78));
		place_word(itype_word(op_sw, 5'd0, 5'd2, 16'h0344));
		place_word(itype_word(op_sw, 5'd0, 5'd10, 16'h0330));
		place_word(jump_word(halt_adr));
		// Load source word
		mem[128] = 32'hcafe_f00d;
	endtask

	task automatic expect_store(input logic [31:0] adr, input logic [31:0] data);
		expected.push_back({adr, data});
	endtask

	task automatic build_expected();
		expect_store(32'h300, 32'h0000_0004);
		expect_store(32'h304, 32'h0000_000a);
		expect_store(32'h308, 32'h0000_0005);
		expect_store(32'h30c, 32'hffff_ffff);
		// Signed compare, -3 < 7
		expect_store(32'h310, 32'h0000_0001);
		expect_store(32'h314, 32'h0000_0000);
		expect_store(32'h318, 32'hffff_fffd);
		expect_store(32'h31c, 32'h0000_8001);
		expect_store(32'h320, 32'h1234_abcd);
		expect_store(32'h324, 32'hcafe_f00d);
		expect_store(32'h328, 32'h0000_0000);
		expect_store(32'h32c, 32'h0000_0007);
		expect_store(32'h330, 32'h1234_abcd);
		for (int a = 0; a <= 32'h60; a += 4) begin
			expected_fetch.push_back(32'(a));
		end
		expected_fetch.push_back(32'h68);
		expected_fetch.push_back(32'h6c);
		expected_fetch.push_back(32'h70);
		expected_fetch.push_back(32'h78);
		expected_fetch.push_back(halt_adr);
	endtask

	task automatic report_test(input string name, input logic ok);
		$display("%s: %s", name, ok ? "pass" : "fail");
		if (ok) begin
			passed++;
		end else begin
			failed++;
		end
	endtask

	task automatic wait_for_store();
		int cycles;
		cycles = 0;
		while (stores.size() == 0 && cycles < max_wait) begin
			@(negedge clk);
			cycles++;
		end
		if (stores.size() == 0) begin
			$display("timeout: no store seen within %0d cycles", max_wait);
			timed_out = 1'b1;
			failed++;
		end
	endtask

	task automatic wait_for_fetches(input int count);
		int cycles;
		cycles = 0;
		while (fetches.size() < count && cycles < max_wait) begin
			@(negedge clk);
			cycles++;
		end
		if (fetches.size() < count) begin
			$display("timeout: only %0d of %0d fetches seen", fetches.size(), count);
			timed_out = 1'b1;
			failed++;
		end
	endtask

	task automatic check_store(input int n);
		store_t got;
		store_t want;
		logic   ok;
		got = stores.pop_front();
		want = expected[n];
		ok = 1'b1;
		assert (got.adr == want.adr) else begin
			$display("error: wb_adr 0x%08h expected 0x%08h", got.adr, want.adr);
			ok = 1'b0;
		end
		assert (got.data == want.data) else begin
			$display("error: wb_wdata 0x%08h expected 0x%08h", got.data, want.data);
			ok = 1'b0;
		end
		report_test($sformatf("store %0d to 0x%0h", n, want.adr), ok);
	endtask

	task automatic check_fetch_order();
		logic [31:0] want;
		logic        ok;
		ok = 1'b1;
		for (int i = 0; i < fetches.size(); i++) begin
			want = (i < expected_fetch.size()) ? expected_fetch[i] : halt_adr;
			assert (fetches[i] == want) else begin
				$display("error: wb_adr 0x%08h expected 0x%08h", fetches[i], want);
				ok = 1'b0;
			end
		end
		report_test("fetch order", ok);
	endtask

	task automatic check_no_extra_stores();
		logic ok;
		ok = (stores.size() == 0);
		assert (ok) else begin
			$display("unexpected store to 0x%08h after the program ended", stores[0].adr);
		end
		report_test("no extra stores", ok);
	endtask

	task automatic finish_run();
		$display("%0d tests passed, %0d failed", passed, failed);
		if (failed == 0 && !timed_out && mips_core_i.asserts_i.failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	initial begin
		int n;
		rst = 1'b1;
		passed = 0;
		failed = 0;
		timed_out = 1'b0;
		load_program();
		build_expected();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		n = 0;
		while (n < expected.size() && !timed_out) begin
			wait_for_store();
			if (!timed_out) begin
				check_store(n);
			end
			n++;
		end
		// Two more fetches put the core in its halt loop
		if (!timed_out) begin
			wait_for_fetches(expected_fetch.size() + 2);
		end
		if (!timed_out) begin
			check_fetch_order();
			check_no_extra_stores();
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+hdl
hdl/mips_pkg.sv
hdl/regfile.sv
hdl/mips_decode.sv
hdl/mips_execute.sv
hdl/mips_result.sv
hdl/mips_core.sv
tb/mips_core_asserts.sv
tb/mips_core_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module mips_core_tb -o mips_sim \
	&& ./obj_dir/mips_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
